//--- hw/lane_pkg.sv
// lane constants shared by the tx path; sync header codes follow the 64b/66b convention
`default_nettype none

package lane_pkg;

	// payload width of one lane word
	localparam int unsigned WORD_W = 64;

	// sync header width placed above the payload
	localparam int unsigned HDR_W = 2;

	// full lane word as carried after the scrambler
	localparam int unsigned LANE_W = HDR_W + WORD_W;

	// header codes, data and control
	// 00 and 11 are never sent, the receiver treats them as sync errors
	localparam logic [HDR_W-1:0] HDR_DATA = 2'b01;
	localparam logic [HDR_W-1:0] HDR_CTRL = 2'b10;

	// scrambler polynomial x^58 + x^39 + 1
	// history length is the polynomial degree
	localparam int unsigned SCRAM_W = 58;

	// inner feedback tap, counted in bits back from the current bit
	localparam int unsigned SCRAM_TAP = 39;

	// history value after reset
	// must be nonzero or a long run of zero payload stays all zero on the line
	localparam logic [SCRAM_W-1:0] SCRAM_SEED = 58'h1f3_a5c7_0e49_b26d;

endpackage

`default_nettype wire

//--- hw/lane_stream_if.sv
// ready/valid word link; a source holds valid and its word until ready is seen high on a clk edge
`timescale 1ns/1ps
`default_nettype none

interface lane_stream_if;

	// word offered by the source
	logic valid;

	// sink can take the word on this edge
	logic ready;

	// header plus payload
	// on the input side only the low WORD_W bits carry data
	logic [lane_pkg::LANE_W-1:0] data;

	// word is a control word, not data
	logic ctrl;

	// producing side
	modport src (
		output valid,
		output data,
		output ctrl,
		input  ready
	);

	// consuming side
	modport snk (
		input  valid,
		input  data,
		input  ctrl,
		output ready
	);

endinterface

`default_nettype wire

//--- hw/ready_skid.sv
// registered skid stage; upstream ready lags downstream ready by one clk, so one extra word may land
`timescale 1ns/1ps
`default_nettype none

module ready_skid (
	input logic         clk,
	input logic         arst,
	lane_stream_if.snk  up,
	lane_stream_if.src  dn
);

	// main output register
	logic [lane_pkg::LANE_W-1:0] main_data_q;
	logic                        main_ctrl_q;

	// backup register, holds the word that was in flight when downstream stalled
	logic [lane_pkg::LANE_W-1:0] bak_data_q;
	logic                        bak_ctrl_q;
	logic                        bak_valid_q;

	// control registers in two copies
	// the _port copies only drive the interface, the _int copies feed the decisions below
	logic valid_port_q;
	logic valid_int_q;
	logic ready_port_q;
	logic ready_int_q;

	// handshake decode
	logic out_take;
	logic in_take;
	logic in_to_main;
	logic in_to_bak;

	// downstream takes the main word this edge
	assign out_take = valid_int_q & dn.ready;

	// upstream hands over a word this edge
	assign in_take = ready_int_q & up.valid;

	// main register is free if empty or being emptied right now
	assign in_to_main = in_take & (dn.ready | ~valid_int_q);

	// otherwise the word is parked in backup
	assign in_to_bak = in_take & ~dn.ready & valid_int_q;

	// control path
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			valid_port_q <= 1'b0;
			valid_int_q  <= 1'b0;
			ready_port_q <= 1'b0;
			ready_int_q  <= 1'b0;
			bak_valid_q  <= 1'b0;
		end else begin
			// ready follows downstream one clk late
			ready_port_q <= dn.ready;
			ready_int_q  <= dn.ready;

			if (out_take) begin
				// main is leaving; refill from backup if anything is parked
				valid_port_q <= bak_valid_q;
				valid_int_q  <= bak_valid_q;
				bak_valid_q  <= 1'b0;
			end

			if (in_to_main) begin
				valid_port_q <= 1'b1;
				valid_int_q  <= 1'b1;
			end

			if (in_to_bak) begin
				bak_valid_q  <= 1'b1;
				// hold off upstream until backup has drained
				ready_port_q <= 1'b0;
				ready_int_q  <= 1'b0;
			end
		end
	end

	// payload path, no reset needed since valid qualifies it
	// backup is only full while ready_int_q is low, so a refill from backup
	// and a new word into main never meet on the same edge
	always_ff @(posedge clk) begin
		if (in_to_main) begin
			main_data_q <= up.data;
			main_ctrl_q <= up.ctrl;
		end else if (out_take && bak_valid_q) begin
			main_data_q <= bak_data_q;
			main_ctrl_q <= bak_ctrl_q;
		end

		if (in_to_bak) begin
			bak_data_q <= up.data;
			bak_ctrl_q <= up.ctrl;
		end
	end

	// port side copies
	assign up.ready = ready_port_q;
	assign dn.valid = valid_port_q;
	assign dn.data  = main_data_q;
	assign dn.ctrl  = main_ctrl_q;

endmodule

`default_nettype wire

//--- hw/lane_scrambler.sv
// self-synchronous x^58+x^39+1 scrambler stage, LSB first; header bits of the input word are ignored
`timescale 1ns/1ps
`default_nettype none

module lane_scrambler (
	input logic         clk,
	input logic         arst,
	lane_stream_if.snk  up,
	lane_stream_if.src  dn
);

	// scrambler history
	// bit 0 is the most recent scrambled bit, bit SCRAM_W-1 the oldest
	logic [lane_pkg::SCRAM_W-1:0] hist_q;

	// history after the current input word has been shifted through
	logic [lane_pkg::SCRAM_W-1:0] hist_next;

	// running history while stepping through the word
	logic [lane_pkg::SCRAM_W-1:0] hist_walk;

	// scrambled payload of the current input word
	logic [lane_pkg::WORD_W-1:0] scr_word;

	// one scrambled bit
	logic scr_bit;

	// header picked from the ctrl flag
	logic [lane_pkg::HDR_W-1:0] hdr;

	// output register
	logic                        out_valid_q;
	logic [lane_pkg::LANE_W-1:0] out_data_q;
	logic                        out_ctrl_q;

	// handshake
	logic up_ready;
	logic accept;

	// free when empty, or when the held word leaves this same edge
	assign up_ready = ~out_valid_q | dn.ready;
	assign accept   = up.valid & up_ready;

	// bit serial scrambler unrolled over the word
	// out bit = in bit ^ scrambled bit 39 back ^ scrambled bit 58 back
	always_comb begin
		hist_walk = hist_q;
		scr_bit   = 1'b0;
		scr_word  = '0;
		for (int i = 0; i < lane_pkg::WORD_W; i++) begin
			scr_bit = up.data[i]
				^ hist_walk[lane_pkg::SCRAM_TAP-1]
				^ hist_walk[lane_pkg::SCRAM_W-1];
			scr_word[i] = scr_bit;
			// newest bit enters at position 0
			hist_walk = {hist_walk[lane_pkg::SCRAM_W-2:0], scr_bit};
		end
		hist_next = hist_walk;
	end

	// sync header is not scrambled
	assign hdr = up.ctrl ? lane_pkg::HDR_CTRL : lane_pkg::HDR_DATA;

	// control state and history
	always_ff @(posedge clk or posedge arst) begin
		if (arst) begin
			out_valid_q <= 1'b0;
			hist_q      <= lane_pkg::SCRAM_SEED;
		end else begin
			if (accept) begin
				out_valid_q <= 1'b1;
				// history only moves with real words, idle and stall keep it
				hist_q      <= hist_next;
			end else if (dn.ready) begin
				// held word went out and nothing new came in
				out_valid_q <= 1'b0;
			end
		end
	end

	// output word
	always_ff @(posedge clk) begin
		if (accept) begin
			out_data_q <= {hdr, scr_word};
			out_ctrl_q <= up.ctrl;
		end
	end

	assign up.ready = up_ready;
	assign dn.valid = out_valid_q;
	assign dn.data  = out_data_q;
	assign dn.ctrl  = out_ctrl_q;

endmodule

`default_nettype wire

//--- hw/tx_lane_path.sv
// tx word path: skid, scrambler, skid; 3 clk latency without stalls, in_ready_o is registered
`timescale 1ns/1ps
`default_nettype none

module tx_lane_path (
	input  logic                        clk,
	input  logic                        arst,
	input  logic                        in_valid_i,
	input  logic                        in_ctrl_i,
	input  logic [lane_pkg::WORD_W-1:0] in_data_i,
	output logic                        in_ready_o,
	output logic                        out_valid_o,
	output logic                        out_ctrl_o,
	output logic [lane_pkg::HDR_W-1:0]  out_hdr_o,
	output logic [lane_pkg::WORD_W-1:0] out_data_o,
	input  logic                        out_ready_i
);

	// boundary links
	lane_stream_if link_in ();
	lane_stream_if link_out ();

	// stage to stage links
	lane_stream_if link_a ();
	lane_stream_if link_b ();

	// input ports onto the boundary link
	// header field is unused on this side
	assign link_in.valid = in_valid_i;
	assign link_in.ctrl  = in_ctrl_i;
	assign link_in.data  = {{lane_pkg::HDR_W{1'b0}}, in_data_i};
	assign in_ready_o    = link_in.ready;

	// register the input before the wide xor tree
	ready_skid u_in_skid (
		.clk  (clk),
		.arst (arst),
		.up   (link_in.snk),
		.dn   (link_a.src)
	);

	// scramble and add the sync header
	lane_scrambler u_scram (
		.clk  (clk),
		.arst (arst),
		.up   (link_a.snk),
		.dn   (link_b.src)
	);

	// cuts the combinational ready of the scrambler from the lane output
	ready_skid u_out_skid (
		.clk  (clk),
		.arst (arst),
		.up   (link_b.snk),
		.dn   (link_out.src)
	);

	// lane word split back into header and payload
	assign out_valid_o    = link_out.valid;
	assign out_ctrl_o     = link_out.ctrl;
	assign out_hdr_o      = link_out.data[lane_pkg::LANE_W-1:lane_pkg::WORD_W];
	assign out_data_o     = link_out.data[lane_pkg::WORD_W-1:0];
	assign link_out.ready = out_ready_i;

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
// free running testbench clock, 20 ns period, starts low at time 0
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o
);

	// half of the 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clk_o = 1'b0;
		forever begin
			#HALF_PERIOD;
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_tx_lane_path.sv
// table driven check of tx_lane_path; scrambler history bit 0 is taken as the most recent bit
`timescale 1ns/1ps
`default_nettype none

module tb_tx_lane_path;

	// rows in the stimulus table
	// the table runs once with open output and once under back-pressure
	localparam int ROWS  = 10;
	localparam int TOTAL = 2 * ROWS;

	// cycles any single wait may take
	localparam int unsigned TIMEOUT = 200;

	localparam logic [31:0] SEED = 32'h5e3f_5ae0;

	// payload per row
	localparam logic [63:0] ROW_DATA [ROWS] = '{
		64'h0000_0000_0000_0000,
		64'hffff_ffff_ffff_ffff,
		64'h0123_4567_89ab_cdef,
		64'hdead_beef_cafe_f00d,
		64'h1e00_0000_0000_0078,
		64'h5555_aaaa_5555_aaaa,
		64'h0000_0000_0000_0001,
		64'h8000_0000_0000_0000,
		64'h0f0f_0f0f_f0f0_f0f0,
		64'h7e7e_7e7e_7e7e_7e7e
	};

	// control flag per row
	localparam bit ROW_CTRL [ROWS] = '{0, 0, 1, 0, 1, 0, 0, 1, 0, 1};

	// idle cycles before each row
	localparam int ROW_GAP [ROWS] = '{0, 0, 0, 2, 0, 3, 0, 1, 0, 0};

	// cycles the output is watched once the last word has left
	localparam int DRAIN_CYCLES = 8;

	logic                        clk;
	logic                        arst;
	logic                        in_valid_i;
	logic                        in_ctrl_i;
	logic [lane_pkg::WORD_W-1:0] in_data_i;
	logic                        in_ready_o;
	logic                        out_valid_o;
	logic                        out_ctrl_o;
	logic [lane_pkg::HDR_W-1:0]  out_hdr_o;
	logic [lane_pkg::WORD_W-1:0] out_data_o;
	logic                        out_ready_i;

	// out_ready_i level when back-pressure is off
	logic ready_hold = 1'b0;

	// random back-pressure on out_ready_i
	logic bp_enable = 1'b0;

	logic [31:0] rnd;

	// rising edges seen so far
	int unsigned cycle_cnt = 0;

	// edge numbers of input transfers with the oldest first
	int unsigned accept_q [$];

	// model results in transfer order
	logic [lane_pkg::WORD_W-1:0] exp_data [TOTAL];
	logic [lane_pkg::HDR_W-1:0]  exp_hdr  [TOTAL];
	logic                        exp_ctrl [TOTAL];

	tb_clk_gen u_clk_gen (
		.clk_o (clk)
	);

	tx_lane_path u_dut (
		.clk         (clk),
		.arst        (arst),
		.in_valid_i  (in_valid_i),
		.in_ctrl_i   (in_ctrl_i),
		.in_data_i   (in_data_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_ctrl_o  (out_ctrl_o),
		.out_hdr_o   (out_hdr_o),
		.out_data_o  (out_data_o),
		.out_ready_i (out_ready_i)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// out_ready_i changes 2 ns after each rising edge
	initial begin
		out_ready_i = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			if (bp_enable) begin
				rnd = $urandom();
				out_ready_i = rnd[0];
			end else begin
				out_ready_i = ready_hold;
			end
		end
	end

	task automatic abort_run();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_equal(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// reference scrambler on a flat bit stream
	// stream[0..57] is the history oldest first, then the new scrambled bits follow
	task automatic scramble_row(input logic [63:0] word,
			inout logic [lane_pkg::SCRAM_W-1:0] hist, output logic [63:0] scr);
		logic stream [0:lane_pkg::SCRAM_W+lane_pkg::WORD_W-1];
		int k;
		for (k = 0; k < lane_pkg::SCRAM_W; k++) begin
			stream[lane_pkg::SCRAM_W-1-k] = hist[k];
		end
		// each bit xors the bits 39 and 58 places earlier in the stream
		for (k = 0; k < lane_pkg::WORD_W; k++) begin
			stream[lane_pkg::SCRAM_W+k] = word[k]
				^ stream[lane_pkg::SCRAM_W+k-lane_pkg::SCRAM_TAP]
				^ stream[k];
			scr[k] = stream[lane_pkg::SCRAM_W+k];
		end
		// last 58 stream bits become the new history with the newest at bit 0
		for (k = 0; k < lane_pkg::SCRAM_W; k++) begin
			hist[k] = stream[lane_pkg::SCRAM_W+lane_pkg::WORD_W-1-k];
		end
	endtask

	// expected words for both passes with one history running across them
	task automatic build_expected();
		logic [lane_pkg::SCRAM_W-1:0] hist;
		logic [63:0] scr;
		int n;
		int r;
		hist = lane_pkg::SCRAM_SEED;
		for (n = 0; n < TOTAL; n++) begin
			r = n % ROWS;
			scramble_row(ROW_DATA[r], hist, scr);
			exp_data[n] = scr;
			exp_ctrl[n] = ROW_CTRL[r];
			exp_hdr[n]  = ROW_CTRL[r] ? lane_pkg::HDR_CTRL : lane_pkg::HDR_DATA;
		end
	endtask

	// starts and ends 2 ns after a rising edge
	task automatic drive_rows();
		int p;
		int g;
		int unsigned waited;
		logic accepted;
		for (p = 0; p < ROWS; p++) begin
			for (g = 0; g < ROW_GAP[p]; g++) begin
				@(posedge clk);
				#2;
			end
			in_data_i  = ROW_DATA[p];
			in_ctrl_i  = ROW_CTRL[p];
			in_valid_i = 1'b1;
			accepted   = 1'b0;
			waited     = 0;
			while (!accepted) begin
				@(negedge clk);
				if (in_ready_o) begin
					// transfer happens on the coming edge
					accepted = 1'b1;
					accept_q.push_back(cycle_cnt + 1);
				end else begin
					waited++;
					if (waited > TIMEOUT) begin
						$display("timeout: in_ready_o stayed low while row %0d was offered", p);
						abort_run();
					end
				end
			end
			@(posedge clk);
			#2;
			in_valid_i = 1'b0;
		end
	endtask

	task automatic collect_rows(input int first, input bit check_latency);
		int got;
		int idx;
		int unsigned idle;
		int unsigned acc_cycle;
		logic held;
		logic [63:0] held_data;
		got  = 0;
		idle = 0;
		held = 1'b0;
		held_data = '0;
		while (got < ROWS) begin
			@(negedge clk);
			// a stalled word must stay on the output unchanged
			if (held) begin
				check_equal("out_valid_o (stalled)", 64'(out_valid_o), 64'd1);
				check_equal("out_data_o (stalled)", out_data_o, held_data);
			end
			held      = out_valid_o & ~out_ready_i;
			held_data = out_data_o;
			if (out_valid_o && out_ready_i) begin
				if (accept_q.size() == 0) begin
					$display("output word %0d has no matching input word", first + got);
					abort_run();
				end
				idx = first + got;
				acc_cycle = accept_q.pop_front();
				check_equal("out_data_o", out_data_o, exp_data[idx]);
				check_equal("out_hdr_o", 64'(out_hdr_o), 64'(exp_hdr[idx]));
				check_equal("out_ctrl_o", 64'(out_ctrl_o), 64'(exp_ctrl[idx]));
				if (check_latency) begin
					check_equal("latency", 64'(cycle_cnt + 1 - acc_cycle), 64'd3);
				end
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT) begin
					$display("timeout: output word %0d never arrived", first + got);
					abort_run();
				end
			end
		end
	endtask

	initial begin
		logic extra_valid;
		arst       = 1'b1;
		in_valid_i = 1'b0;
		in_ctrl_i  = 1'b0;
		in_data_i  = '0;
		rnd        = $urandom(SEED);
		build_expected();

		// reset over three rising edges
		repeat (3) @(posedge clk);
		#2;
		arst = 1'b0;

		// no edge since release and out_ready_i still low
		@(negedge clk);
		check_equal("in_ready_o", 64'(in_ready_o), 64'd0);
		check_equal("out_valid_o", 64'(out_valid_o), 64'd0);
		ready_hold = 1'b1;

		// open output and fixed latency
		@(posedge clk);
		#2;
		fork
			drive_rows();
			collect_rows(0, 1'b1);
		join

		// same table again with random back-pressure
		bp_enable = 1'b1;
		@(posedge clk);
		#2;
		fork
			drive_rows();
			collect_rows(ROWS, 1'b0);
		join
		bp_enable = 1'b0;

		// the last word leaves on this edge and the output must stay empty after it
		@(posedge clk);
		extra_valid = 1'b0;
		repeat (DRAIN_CYCLES) begin
			@(negedge clk);
			if (out_valid_o) begin
				extra_valid = 1'b1;
			end
		end
		if (!extra_valid) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("out_valid_o rose again after the last expected output word");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- flist.f
hw/lane_pkg.sv
hw/lane_stream_if.sv
hw/ready_skid.sv
hw/lane_scrambler.sv
hw/tx_lane_path.sv
testbench/tb_clk_gen.sv
testbench/tb_tx_lane_path.sv

//--- Makefile
# Verilator build and run of the tx lane path testbench

TOP := tb_tx_lane_path

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f flist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
